/* common/pcie_pkg.sv */
/*
 * PCIe completer package
 * Request, completion and decoded-access types, plus the BAR0 register map
 */
package pcie_pkg;

    // BAR0 aperture in address bits
    localparam int unsigned BAR0_APERTURE = 24;

    // register window; anything at or above is unsupported
    localparam logic [BAR0_APERTURE-1:0] REG_MAP_BYTES = 24'd16;

    // dword register indices, from address bits 3:2
    localparam logic [1:0] REG_ID        = 2'd0;
    localparam logic [1:0] REG_SCRATCH   = 2'd1;
    localparam logic [1:0] REG_LED       = 2'd2;
    localparam logic [1:0] REG_REQ_COUNT = 2'd3;

    localparam logic [31:0] CORE_ID = 32'h5043_4301;

    // activity LED hold time in cycles
    localparam int unsigned ACT_STRETCH = 8;
    localparam int unsigned ACT_CNT_W   = $clog2(ACT_STRETCH + 1);

    typedef enum logic [1:0] {
        req_mem_read  = 2'd0,
        req_mem_write = 2'd1
    } req_type_t;

    // encodings follow the PCIe completion status field
    typedef enum logic [2:0] {
        cpl_sc = 3'b000,
        cpl_ur = 3'b001
    } cpl_status_t;

    typedef struct packed {
        req_type_t                req_type;
        logic [2:0]               bar_id;
        logic [BAR0_APERTURE-1:0] addr;
        logic [7:0]               tag;
        logic [3:0]               first_be;
        logic [31:0]              data;
    } cq_req_t;

    typedef struct packed {
        logic [7:0]  tag;
        cpl_status_t status;
        logic [31:0] data;
    } cc_cpl_t;

    // decoded access, decoder to register file and encoder
    typedef struct packed {
        logic        is_read;
        logic        is_ur;
        logic        is_write;
        logic [1:0]  reg_index;
        logic [7:0]  tag;
        logic [3:0]  first_be;
        logic [31:0] data;
    } reg_access_t;

endpackage

/* logic/cq_decoder.sv */
/*
 * CQ request decoder
 * Accepts one request per handshake, classifies it against BAR0 and
 * holds the decoded access for one stage
 */
`timescale 1ns/1ps

module cq_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cq_valid,
    input  pcie_pkg::cq_req_t      cq_req,
    output logic                   cq_ready,
    input  logic                   cc_full,
    output logic                   access_valid,
    output pcie_pkg::reg_access_t  access
);

    import pcie_pkg::*;

    reg_access_t dec;
    logic        stage_valid;
    logic        stall;

    // a held read can only move on when the completion side has room
    assign stall    = stage_valid && access.is_read && cc_full;
    assign cq_ready = !stall;
    // register file sees each access once, in the cycle it leaves the stage
    assign access_valid = stage_valid && !stall;

    always_comb begin
        logic unsupported;
        logic is_rd;

        unsupported = (cq_req.bar_id != 3'd0) || (cq_req.addr >= REG_MAP_BYTES);
        is_rd       = (cq_req.req_type == req_mem_read);

        dec.is_read   = is_rd;
        dec.is_ur     = unsupported;
        // writes with no enabled bytes are dropped here
        dec.is_write  = !is_rd && !unsupported && (cq_req.first_be != 4'd0);
        dec.reg_index = cq_req.addr[3:2];
        dec.tag       = cq_req.tag;
        dec.first_be  = cq_req.first_be;
        dec.data      = cq_req.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else if (cq_ready) begin
            stage_valid <= cq_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cq_ready && cq_valid) begin
            access <= dec;
        end
    end

    // stalled read must reach the register file unchanged
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> stage_valid && $stable(access)
    );

endmodule

/* logic/bar_regs.sv */
/*
 * BAR0 register file
 * ID, byte-enabled scratch, LED control and request counter, with read
 * capture for the completion path and the error pulses
 */
`timescale 1ns/1ps

module bar_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   access_valid,
    input  pcie_pkg::reg_access_t  access,
    output logic                   rd_valid,
    output pcie_pkg::reg_access_t  rd_access,
    output logic [31:0]            rd_data,
    output logic [1:0]             led_ctrl,
    output logic                   access_strobe,
    output logic                   status_error_cor,
    output logic                   status_error_uncor
);

    import pcie_pkg::*;

    logic [31:0] scratch_reg;
    logic [1:0]  led_reg;
    logic [31:0] req_count;
    logic [31:0] rd_mux;
    logic        wr_en;
    logic        dropped;

    assign wr_en    = access_valid && access.is_write;
    // supported write with first_be of zero
    assign dropped  = !access.is_ur && !access.is_read && !access.is_write;
    assign led_ctrl = led_reg;

    always_comb begin
        case (access.reg_index)
            REG_ID:        rd_mux = CORE_ID;
            REG_SCRATCH:   rd_mux = scratch_reg;
            REG_LED:       rd_mux = {30'd0, led_reg};
            REG_REQ_COUNT: rd_mux = req_count;
            default:       rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch_reg        <= 32'd0;
            led_reg            <= 2'd0;
            req_count          <= 32'd0;
            rd_valid           <= 1'b0;
            access_strobe      <= 1'b0;
            status_error_cor   <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            rd_valid           <= access_valid && access.is_read;
            access_strobe      <= access_valid;
            status_error_uncor <= access_valid && access.is_ur;
            status_error_cor   <= access_valid && dropped;

            // every request counts, so a read sees only earlier ones
            if (access_valid) begin
                req_count <= req_count + 32'd1;
            end

            if (wr_en && access.reg_index == REG_SCRATCH) begin
                for (int i = 0; i < 4; i++) begin
                    if (access.first_be[i]) begin
                        scratch_reg[8*i +: 8] <= access.data[8*i +: 8];
                    end
                end
            end

            if (wr_en && access.reg_index == REG_LED && access.first_be[0]) begin
                led_reg <= access.data[1:0];
            end
        end
    end

    // read capture, unsupported reads included
    always_ff @(posedge clk) begin
        if (access_valid && access.is_read) begin
            rd_access <= access;
            rd_data   <= rd_mux;
        end
    end

endmodule

/* logic/cc_encoder.sv */
/*
 * CC completion encoder
 * Forms SC or UR completions and holds them until the host side accepts
 */
`timescale 1ns/1ps

module cc_encoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rd_valid,
    input  pcie_pkg::reg_access_t  rd_access,
    input  logic [31:0]            rd_data,
    output logic                   cc_valid,
    input  logic                   cc_ready,
    output pcie_pkg::cc_cpl_t      cc_cpl,
    output logic                   cc_full
);

    import pcie_pkg::*;

    // a read already in the register stage counts as occupying us
    assign cc_full = cc_valid || rd_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc_valid <= 1'b0;
        end else if (rd_valid) begin
            cc_valid <= 1'b1;
        end else if (cc_ready) begin
            cc_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            cc_cpl.tag <= rd_access.tag;
            if (rd_access.is_ur) begin
                cc_cpl.status <= cpl_ur;
                cc_cpl.data   <= 32'd0;
            end else begin
                cc_cpl.status <= cpl_sc;
                cc_cpl.data   <= rd_data;
            end
        end
    end

    // payload held under back-pressure
    a_cc_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        cc_valid && !cc_ready |=> cc_valid && $stable(cc_cpl)
    );

    // decoder stall must keep reads out while a completion is stuck
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid |-> !cc_valid || cc_ready
    );

endmodule

/* logic/led_status.sv */
/*
 * QSFP LED driver
 * Stretched activity indication and registered status LEDs
 */
`timescale 1ns/1ps

module led_status (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       access_strobe,
    input  logic [1:0] led_ctrl,
    output logic       qsfp_led_act,
    output logic       qsfp_led_stat_g,
    output logic       qsfp_led_stat_y
);

    import pcie_pkg::*;

    logic [ACT_CNT_W-1:0] act_cnt;

    assign qsfp_led_act = (act_cnt != '0);

    // reload on each access, then count down to dark
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_cnt <= '0;
        end else if (access_strobe) begin
            act_cnt <= ACT_CNT_W'(ACT_STRETCH);
        end else if (act_cnt != '0) begin
            act_cnt <= act_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qsfp_led_stat_g <= 1'b0;
            qsfp_led_stat_y <= 1'b0;
        end else begin
            qsfp_led_stat_g <= led_ctrl[0];
            qsfp_led_stat_y <= led_ctrl[1];
        end
    end

endmodule

/* logic/fpga_core.sv */
/*
 * FPGA core, completer side
 * CQ decode, BAR0 registers, CC completions and LED/status outputs
 */
`timescale 1ns/1ps

module fpga_core (
    input  logic               clk,
    input  logic               rst_n,

    // completer request
    input  logic               cq_valid,
    input  pcie_pkg::cq_req_t  cq_req,
    output logic               cq_ready,

    // completer completion
    output logic               cc_valid,
    output pcie_pkg::cc_cpl_t  cc_cpl,
    input  logic               cc_ready,

    output logic               qsfp_led_act,
    output logic               qsfp_led_stat_g,
    output logic               qsfp_led_stat_y,

    output logic               status_error_cor,
    output logic               status_error_uncor
);

    import pcie_pkg::*;

    logic        access_valid;
    reg_access_t access;
    logic        rd_valid;
    reg_access_t rd_access;
    logic [31:0] rd_data;
    logic [1:0]  led_ctrl;
    logic        access_strobe;
    logic        cc_full;

    cq_decoder cq_decoder_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cq_valid     (cq_valid),
        .cq_req       (cq_req),
        .cq_ready     (cq_ready),
        .cc_full      (cc_full),
        .access_valid (access_valid),
        .access       (access)
    );

    bar_regs bar_regs_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .access_valid       (access_valid),
        .access             (access),
        .rd_valid           (rd_valid),
        .rd_access          (rd_access),
        .rd_data            (rd_data),
        .led_ctrl           (led_ctrl),
        .access_strobe      (access_strobe),
        .status_error_cor   (status_error_cor),
        .status_error_uncor (status_error_uncor)
    );

    cc_encoder cc_encoder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (rd_valid),
        .rd_access (rd_access),
        .rd_data   (rd_data),
        .cc_valid  (cc_valid),
        .cc_ready  (cc_ready),
        .cc_cpl    (cc_cpl),
        .cc_full   (cc_full)
    );

    led_status led_status_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .access_strobe   (access_strobe),
        .led_ctrl        (led_ctrl),
        .qsfp_led_act    (qsfp_led_act),
        .qsfp_led_stat_g (qsfp_led_stat_g),
        .qsfp_led_stat_y (qsfp_led_stat_y)
    );

endmodule

/* dv/tb_fpga_core.sv */
/*
 * Testbench for the PCIe completer core
 * Directed tests of the BAR0 registers, LEDs, error pulses and CC back-pressure
 */
`timescale 1ns/1ps

module tb_fpga_core;

    import pcie_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 20;
    localparam int PULSE_WINDOW = 4;
    // rough length of all tests in clock cycles
    localparam int TEST_CYCLES  = 300;
    localparam int WATCHDOG_NS  = (TEST_CYCLES * 4 + 100) * CLK_PERIOD;

    // byte addresses, register index in bits 3:2
    localparam logic [23:0] ADDR_ID      = {20'd0, REG_ID, 2'b00};
    localparam logic [23:0] ADDR_SCRATCH = {20'd0, REG_SCRATCH, 2'b00};
    localparam logic [23:0] ADDR_LED     = {20'd0, REG_LED, 2'b00};
    localparam logic [23:0] ADDR_COUNT   = {20'd0, REG_REQ_COUNT, 2'b00};

    logic    clk;
    logic    rst_n;
    logic    cq_valid;
    cq_req_t cq_req;
    logic    cq_ready;
    logic    cc_valid;
    cc_cpl_t cc_cpl;
    logic    cc_ready;
    logic    qsfp_led_act;
    logic    qsfp_led_stat_g;
    logic    qsfp_led_stat_y;
    logic    status_error_cor;
    logic    status_error_uncor;

    // expected model state
    logic [31:0] lcg_state      = 32'd15;
    logic [31:0] scratch_shadow = 32'd0;
    logic [1:0]  led_shadow     = 2'd0;
    logic [31:0] accepted_count = 32'd0;
    logic [31:0] last_count     = 32'd0;
    logic [31:0] cor_count      = 32'd0;
    logic [31:0] uncor_count    = 32'd0;
    logic [31:0] exp_cor        = 32'd0;
    logic [31:0] exp_uncor      = 32'd0;

    fpga_core dut0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .cq_valid           (cq_valid),
        .cq_req             (cq_req),
        .cq_ready           (cq_ready),
        .cc_valid           (cc_valid),
        .cc_cpl             (cc_cpl),
        .cc_ready           (cc_ready),
        .qsfp_led_act       (qsfp_led_act),
        .qsfp_led_stat_g    (qsfp_led_stat_g),
        .qsfp_led_stat_y    (qsfp_led_stat_y),
        .status_error_cor   (status_error_cor),
        .status_error_uncor (status_error_uncor)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // error pulses counted mid-cycle
    always @(negedge clk) begin
        if (rst_n && status_error_cor) begin
            cor_count = cor_count + 32'd1;
        end
        if (rst_n && status_error_uncor) begin
            uncor_count = uncor_count + 32'd1;
        end
    end

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic fail_with(input string what);
        $display("Failure at %0t: %s", $time, what);
        stop_on_error();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
            stop_on_error();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] next_tag();
        logic [31:0] r;
        r = lcg_next();
        return r[15:8];
    endfunction

    function automatic cq_req_t build_req(input req_type_t kind, input logic [2:0] bar,
                                          input logic [23:0] addr, input logic [7:0] tag,
                                          input logic [3:0] be, input logic [31:0] data);
        cq_req_t req;
        req.req_type = kind;
        req.bar_id   = bar;
        req.addr     = addr;
        req.tag      = tag;
        req.first_be = be;
        req.data     = data;
        return req;
    endfunction

    // only the enabled bytes take the new value
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0] be);
        logic [31:0] result;
        result = old_val;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic send_req(input cq_req_t req);
        int waited;
        @(posedge clk);
        #2;
        cq_req   = req;
        cq_valid = 1'b1;
        waited   = 0;
        @(negedge clk);
        while (!cq_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_with("request not accepted, cq_ready stayed low");
            end
            @(negedge clk);
        end
        @(posedge clk);
        // counter register sees only requests accepted before this one
        last_count     = accepted_count;
        accepted_count = accepted_count + 32'd1;
        #2;
        cq_valid = 1'b0;
    endtask

    task automatic expect_cpl(input logic [7:0] tag, input cpl_status_t status,
                              input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cc_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_with("no completion arrived on CC");
            end
            @(negedge clk);
        end
        check_value("cc_cpl.tag", 32'(cc_cpl.tag), 32'(tag));
        check_value("cc_cpl.status", 32'(cc_cpl.status), 32'(status));
        check_value("cc_cpl.data", cc_cpl.data, data);
        // transfer on this edge, cc_ready is high
        @(posedge clk);
    endtask

    task automatic read_expect(input logic [23:0] addr, input logic [31:0] expected);
        logic [7:0] tag;
        tag = next_tag();
        send_req(build_req(req_mem_read, 3'd0, addr, tag, 4'hf, 32'd0));
        expect_cpl(tag, cpl_sc, expected);
    endtask

    task automatic write_reg(input logic [23:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        send_req(build_req(req_mem_write, 3'd0, addr, next_tag(), be, data));
    endtask

    task automatic check_error_pulse(input logic uncorrectable);
        repeat (PULSE_WINDOW) @(posedge clk);
        if (uncorrectable) begin
            exp_uncor = exp_uncor + 32'd1;
        end else begin
            exp_cor = exp_cor + 32'd1;
        end
        // running totals also catch stray or stretched pulses
        check_value("status_error_uncor pulses", uncor_count, exp_uncor);
        check_value("status_error_cor pulses", cor_count, exp_cor);
    endtask

    task automatic ur_read_check(input logic [2:0] bar, input logic [23:0] addr);
        logic [7:0] tag;
        tag = next_tag();
        send_req(build_req(req_mem_read, bar, addr, tag, 4'hf, 32'd0));
        fork
            expect_cpl(tag, cpl_ur, 32'd0);
            check_error_pulse(1'b1);
        join
    endtask

    task automatic reset_and_id();
        @(negedge clk);
        check_value("cc_valid", 32'(cc_valid), 32'd0);
        check_value("status_error_cor", 32'(status_error_cor), 32'd0);
        check_value("status_error_uncor", 32'(status_error_uncor), 32'd0);
        check_value("qsfp_led_act", 32'(qsfp_led_act), 32'd0);
        check_value("qsfp_led_stat_g", 32'(qsfp_led_stat_g), 32'd0);
        check_value("qsfp_led_stat_y", 32'(qsfp_led_stat_y), 32'd0);
        check_value("cq_ready", 32'(cq_ready), 32'd1);
        read_expect(ADDR_ID, CORE_ID);
    endtask

    task automatic scratch_byte_enables();
        logic [3:0]  patterns [6] = '{4'hf, 4'h1, 4'h6, 4'h8, 4'ha, 4'h5};
        logic [31:0] data;
        for (int i = 0; i < 6; i++) begin
            data = lcg_next();
            write_reg(ADDR_SCRATCH, patterns[i], data);
            scratch_shadow = merge_bytes(scratch_shadow, data, patterns[i]);
            read_expect(ADDR_SCRATCH, scratch_shadow);
        end
        // ID is read-only
        write_reg(ADDR_ID, 4'hf, lcg_next());
        read_expect(ADDR_ID, CORE_ID);
    endtask

    task automatic led_outputs();
        for (int v = 1; v <= 3; v++) begin
            write_reg(ADDR_LED, 4'hf, 32'(v));
            led_shadow = v[1:0];
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_value("qsfp_led_stat_g", 32'(qsfp_led_stat_g), 32'(led_shadow[0]));
            check_value("qsfp_led_stat_y", 32'(qsfp_led_stat_y), 32'(led_shadow[1]));
            check_value("qsfp_led_act", 32'(qsfp_led_act), 32'd1);
        end
        read_expect(ADDR_LED, {30'd0, led_shadow});
        repeat (ACT_STRETCH + 5) @(posedge clk);
        @(negedge clk);
        check_value("qsfp_led_act", 32'(qsfp_led_act), 32'd0);
    endtask

    task automatic error_responses();
        ur_read_check(3'd2, ADDR_SCRATCH);
        ur_read_check(3'd0, 24'h20);
        // no enabled bytes, dropped with a correctable error
        write_reg(ADDR_SCRATCH, 4'h0, lcg_next());
        check_error_pulse(1'b0);
        read_expect(ADDR_SCRATCH, scratch_shadow);
    endtask

    task automatic backpressure_order();
        logic [7:0]  tags [$];
        logic [31:0] counts [$];
        logic [7:0]  tag;
        logic [31:0] count;
        int          sent;
        @(posedge clk);
        #2;
        cc_ready = 1'b0;
        sent     = 0;
        // count reads pile up until the decoder stalls
        do begin
            if (sent == 3) begin
                fail_with("cq_ready did not drop within three reads");
            end
            tag = next_tag();
            send_req(build_req(req_mem_read, 3'd0, ADDR_COUNT, tag, 4'hf, 32'd0));
            tags.push_back(tag);
            counts.push_back(last_count);
            sent++;
            @(negedge clk);
        end while (cq_ready);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("cq_ready", 32'(cq_ready), 32'd0);
        check_value("cc_valid", 32'(cc_valid), 32'd1);
        @(posedge clk);
        #2;
        cc_ready = 1'b1;
        while (tags.size() > 0) begin
            tag   = tags.pop_front();
            count = counts.pop_front();
            expect_cpl(tag, cpl_sc, count);
        end
        @(negedge clk);
        check_value("cc_valid", 32'(cc_valid), 32'd0);
        check_value("cq_ready", 32'(cq_ready), 32'd1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_with("watchdog expired before the tests finished");
    end

    initial begin
        rst_n    = 1'b0;
        cq_valid = 1'b0;
        cq_req   = '0;
        cc_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        reset_and_id();
        scratch_byte_enables();
        led_outputs();
        error_responses();
        backpressure_order();

        repeat (PULSE_WINDOW) @(posedge clk);
        check_value("status_error_uncor pulses", uncor_count, exp_uncor);
        check_value("status_error_cor pulses", cor_count, exp_cor);
        $display("Verification passed");
        $finish;
    end

endmodule

/* all.f */
common/pcie_pkg.sv
logic/cq_decoder.sv
logic/bar_regs.sv
logic/cc_encoder.sv
logic/led_status.sv
logic/fpga_core.sv
dv/tb_fpga_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the completer core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpga_core -f all.f \
    --Mdir "$BUILD_DIR" -o tb_fpga_core > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/tb_fpga_core" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Verification failed" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "PASS"
exit 0
